// File: Makefile
# Verilator build and run of the LSU testbench

SRCS := $(shell cat list.f)

# Rebuilt only when a source or the file list changes
obj_dir/Vlsu_tb: list.f $(SRCS)
	verilator --binary --timing --assert --top-module lsu_tb -f list.f -o Vlsu_tb

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: bench/lsu_tb.sv
// Self-checking testbench for lsu_top against a byte-wide shadow memory
// Random loads and stores of every size and offset, with strobe and latency checks
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int SHADOW_BYTES = 1024;
    localparam int WAIT_LIMIT   = 20;

    logic         clk = 1'b0;
    logic         rstz;
    logic         start;
    logic         ld;
    logic         st;
    logic [31:0]  addr;
    logic [31:0]  store_data;
    access_size_t data_size;
    logic         data_uns;
    logic [4:0]   rd;
    logic         done;
    logic         load_en;
    logic [31:0]  load_data;
    logic [4:0]   load_rd;

    // Expected memory contents, one entry per byte
    logic [7:0]   shadow [SHADOW_BYTES];
    integer       seed = 32'h34e37093;
    int           errors = 0;
    int           checks = 0;
    int           timeouts = 0;
    bit           hung = 1'b0;

    lsu_top #(
        .MEM_WORDS   (256),
        .MEM_LATENCY (2)
    ) DUT (
        .clk        (clk),
        .rstz       (rstz),
        .start      (start),
        .ld         (ld),
        .st         (st),
        .addr       (addr),
        .store_data (store_data),
        .data_size  (data_size),
        .data_uns   (data_uns),
        .rd         (rd),
        .done       (done),
        .load_en    (load_en),
        .load_data  (load_data),
        .load_rd    (load_rd)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ==================================================================
    // Strobe rules on every rising edge

    assert property (@(posedge clk) !rstz |-> (!done && !load_en))
    else begin
        errors++;
        $display("error t=%0t done=%b load_en=%b in reset, expected 0", $time, done, load_en);
    end

    assert property (@(posedge clk) disable iff (!rstz) load_en |-> done)
    else begin
        errors++;
        $display("error at %0t: load_en pulsed without done", $time);
    end

    // Single-cycle done pulse
    assert property (@(posedge clk) disable iff (!rstz) done |=> !done)
    else begin
        errors++;
        $display("error at %0t: done stayed high for more than one cycle", $time);
    end

    // ==================================================================
    // Reference model

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Half at lane 3, or any unaligned word
    function automatic bit crosses(input logic [31:0] a, input logic [1:0] sz);
        return (sz == 2'd1 && a[1:0] == 2'd3) || (sz == 2'd2 && a[1:0] != 2'd0);
    endfunction

    // Little-endian gather of 1, 2 or 4 bytes, then extension
    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [1:0] sz,
                                                  input bit uns);
        logic [31:0] v;
        logic [9:0]  b;
        v = '0;
        for (int i = 0; i < (1 << sz); i++) begin
            b = 10'(a + 32'(i));
            v[8*i +: 8] = shadow[b];
        end
        if (sz == 2'd0 && !uns) v = {{24{v[7]}}, v[7:0]};
        if (sz == 2'd1 && !uns) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    // Only the addressed bytes change
    function automatic void update_shadow(input logic [31:0] a, input logic [1:0] sz,
                                          input logic [31:0] data);
        logic [9:0] b;
        for (int i = 0; i < (1 << sz); i++) begin
            b = 10'(a + 32'(i));
            shadow[b] = data[8*i +: 8];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("error t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // One load or store, start to done; ghost adds a start pulse while busy
    task automatic run_op(input bit is_load, input logic [31:0] a, input logic [1:0] sz,
                          input bit uns, input logic [31:0] data, input logic [4:0] reg_idx,
                          input bit ghost);
        int          cycles;
        bit          seen;
        logic [31:0] expect_val;
        cycles = 0;
        seen = 1'b0;
        expect_val = expected_load(a, sz, uns);
        @(posedge clk);
        start      <= 1'b1;
        ld         <= is_load;
        st         <= !is_load;
        addr       <= a;
        store_data <= data;
        data_size  <= access_size_t'(sz);
        data_uns   <= uns;
        rd         <= reg_idx;
        @(posedge clk);
        start <= 1'b0;
        if (!is_load) update_shadow(a, sz, data);
        // Count cycles from the start edge, sampled mid-cycle
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                start <= ghost && (cycles == 1);
                if (ghost && cycles == 1) begin
                    ld <= !is_load;
                    st <= is_load;
                end
            end
        end
        if (!seen) begin
            timeouts++;
            hung = 1'b1;
            $display("timeout: no done within %0d cycles of a start at address %h", WAIT_LIMIT, a);
        end else begin
            // Aligned 1+L, crossing 1+2L
            check_value("done", 32'(crosses(a, sz) ? 5 : 3), 32'(cycles));
            check_value("load_en", 32'(is_load), 32'(load_en));
            if (is_load) begin
                check_value("load_data", expect_val, load_data);
                check_value("load_rd", 32'(reg_idx), 32'(load_rd));
            end
        end
    endtask

    // ==================================================================
    // Stimulus

    initial begin
        int          n;
        int          off;
        bit          is_load;
        bit          uns;
        bit          ghost;
        logic [1:0]  sz;
        logic [31:0] a;
        logic [31:0] data;
        logic [4:0]  reg_idx;
        rstz       = 1'b0;
        start      = 1'b0;
        ld         = 1'b0;
        st         = 1'b0;
        addr       = '0;
        store_data = '0;
        data_size  = BYTE;
        data_uns   = 1'b0;
        rd         = '0;
        for (int b = 0; b < SHADOW_BYTES; b++) shadow[b] = 8'h00;

        // Reset for 5 cycles, strobes quiet before and after release
        repeat (5) begin
            @(negedge clk);
            check_value("done", 32'h0, 32'(done));
            check_value("load_en", 32'h0, 32'(load_en));
        end
        @(posedge clk);
        rstz <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("done", 32'h0, 32'(done));
            check_value("load_en", 32'h0, 32'(load_en));
        end

        // Word stores over the first 64 words and one more
        for (n = 0; n < 65 && !hung; n++) begin
            data = $random(seed);
            run_op(1'b0, 32'(n * 4), 2'd2, 1'b0, data, 5'd0, 1'b0);
        end

        // Aligned loads of each size
        for (n = 0; n < 48 && !hung; n++) begin
            sz = 2'(rand_below(3));
            if (sz == 2'd0) off = rand_below(4);
            else if (sz == 2'd1) off = 2 * rand_below(2);
            else off = 0;
            a       = 32'(rand_below(64) * 4 + off);
            uns     = 1'(rand_below(2));
            reg_idx = 5'(rand_below(32));
            ghost   = (rand_below(4) == 0);
            run_op(1'b1, a, sz, uns, 32'h0, reg_idx, ghost);
        end

        // Crossing loads, half at lane 3 and words at lanes 1 to 3
        for (n = 0; n < 32 && !hung; n++) begin
            if (rand_below(4) == 0) begin
                sz  = 2'd1;
                off = 3;
            end else begin
                sz  = 2'd2;
                off = 1 + rand_below(3);
            end
            a       = 32'(rand_below(64) * 4 + off);
            uns     = 1'(rand_below(2));
            reg_idx = 5'(rand_below(32));
            ghost   = (rand_below(4) == 0);
            run_op(1'b1, a, sz, uns, 32'h0, reg_idx, ghost);
        end

        // Mixed traffic; neighbours of each store are read back
        for (n = 0; n < 200 && !hung; n++) begin
            is_load = 1'(rand_below(2));
            sz      = 2'(rand_below(3));
            a       = 32'(4 + rand_below(60) * 4 + rand_below(4));
            uns     = 1'(rand_below(2));
            data    = $random(seed);
            reg_idx = 5'(rand_below(32));
            ghost   = (rand_below(4) == 0);
            run_op(is_load, a, sz, uns, data, reg_idx, ghost);
            if (!is_load && !hung) begin
                run_op(1'b1, a - 32'd1, 2'd0, 1'b1, 32'h0, reg_idx, 1'b0);
                run_op(1'b1, a + (32'd1 << sz), 2'd0, 1'b1, 32'h0, reg_idx, 1'b0);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/data_bus_if.sv
// Word-aligned data memory bus between the LSU and the data SRAM
// The LSU takes the lsu modport, the memory takes the mem modport
`timescale 1ns/1ps
`default_nettype none

interface data_bus_if;
    import lsu_pkg::*;

    // Request side, always word aligned
    logic [DATA_W-1:0]    addr;
    logic [DATA_W-1:0]    wr_data;
    logic [NUM_LANES-1:0] wr_mask;
    logic                 rd_req;
    logic                 wr_req;

    // Response side, rd_data valid with gnt on reads
    logic [DATA_W-1:0]    rd_data;
    logic                 gnt;

    modport lsu (
        output addr,
        output wr_data,
        output wr_mask,
        output rd_req,
        output wr_req,
        input  rd_data,
        input  gnt
    );

    modport mem (
        input  addr,
        input  wr_data,
        input  wr_mask,
        input  rd_req,
        input  wr_req,
        output rd_data,
        output gnt
    );

endinterface

`default_nettype wire

// File: design/data_sram.sv
// Word-addressed data memory with byte lane writes and a fixed grant latency
// Accepts one request when idle; gnt follows MEM_LATENCY cycles later
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic    clk,
    input  logic    rstz,
    data_bus_if.mem bus
);
    import lsu_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    // Word array starts out all zero
    logic [DATA_W-1:0] mem [MEM_WORDS] = '{default: '0};

    logic [IDX_W-1:0]  idx;
    logic              busy_q;
    logic              gnt_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              accept;
    logic [DATA_W-1:0] rd_data_q;

    // Word index wraps at the array depth
    assign idx = IDX_W'(bus.addr[DATA_W-1:2] % MEM_WORDS);

    // Grant cycle counts as idle for back-to-back requests
    assign accept = (!busy_q || gnt_q) && (bus.rd_req || bus.wr_req);

    // ==================================================================
    // Accept/grant timing

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            busy_q <= 1'b0;
            gnt_q  <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(MEM_LATENCY - 1);
            gnt_q  <= (MEM_LATENCY == 1);
        end else if (gnt_q) begin
            busy_q <= 1'b0;
            gnt_q  <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - CNT_W'(1);
            gnt_q <= (cnt_q == CNT_W'(1));
        end
    end

    // Array access at acceptance
    always_ff @(posedge clk) begin
        if (accept && bus.wr_req) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (bus.wr_mask[i]) mem[idx][8*i +: 8] <= bus.wr_data[8*i +: 8];
            end
        end
        if (accept && bus.rd_req) rd_data_q <= mem[idx];
    end

    assign bus.gnt     = gnt_q;
    assign bus.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: design/lsu.sv
// Load/store sequencer, splits crossing accesses into two word accesses
// Driven by the writeback stage with start strobes, talks to memory over data_bus_if
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                       clk,
    input  logic                       rstz,
    input  logic                       start,
    input  logic                       ld,
    input  logic                       st,
    input  logic [lsu_pkg::DATA_W-1:0] addr,
    input  logic [lsu_pkg::DATA_W-1:0] store_data,
    input  lsu_pkg::access_size_t      data_size,
    input  logic                       data_uns,
    input  logic [4:0]                 rd,
    output logic                       done,
    output logic                       load_en,
    output logic [lsu_pkg::DATA_W-1:0] load_data,
    output logic [4:0]                 load_rd,
    data_bus_if.lsu                    bus
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        SECOND,
        FINISH
    } state_t;

    state_t state, next_state;

    logic              go;
    logic              live_cross;
    logic [DATA_W-1:0] aligned_addr;
    logic              use_second;
    logic              rd_gnt;

    // Operation captured at start
    logic              op_load;
    logic [4:0]        op_rd;
    access_size_t      op_size;
    logic              op_uns;
    logic [1:0]        op_offset;
    logic              op_cross;
    logic [DATA_W-1:0] op_store_data;
    logic [DATA_W-1:0] word_addr;
    logic [DATA_W-1:0] next_addr;
    mem_word_u         prev_word;

    // Aligner hookup
    logic [DATA_W-1:0]    st_data;
    logic [1:0]           st_offset;
    access_size_t         st_size;
    mem_word_u            first_data, second_data;
    logic [NUM_LANES-1:0] first_mask, second_mask;
    logic [DATA_W-1:0]    load_result;

    // ==================================================================
    // Sequencer

    // Only an idle LSU takes a new operation
    assign go = (state == IDLE) && start && (ld || st);

    assign aligned_addr = {addr[DATA_W-1:2], 2'b00};
    assign live_cross   = (data_size == HALF && addr[1:0] == 2'b11)
                       || (data_size == WORD && addr[1:0] != 2'b00);

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:   if (go) next_state = FIRST;
            // Crossing access needs the following word too
            FIRST:  if (bus.gnt) next_state = op_cross ? SECOND : FINISH;
            SECOND: if (bus.gnt) next_state = FINISH;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (go) begin
            op_load       <= ld;
            op_rd         <= rd;
            op_size       <= data_size;
            op_uns        <= data_uns;
            op_offset     <= addr[1:0];
            op_cross      <= live_cross;
            op_store_data <= store_data;
            word_addr     <= aligned_addr;
            next_addr     <= aligned_addr + DATA_W'(4);
        end
        // Keep each read word, second grant overwrites the partial result
        if (rd_gnt) begin
            prev_word <= bus.rd_data;
            load_data <= load_result;
        end
    end

    assign rd_gnt = bus.gnt && op_load && (state == FIRST || state == SECOND);

    // Writeback strobes
    assign done    = (state == FINISH);
    assign load_en = done && op_load;
    assign load_rd = op_rd;

    // ==================================================================
    // Memory bus, look-ahead addressing

    // Second word goes out in the grant cycle of the first
    assign use_second = (state == FIRST && bus.gnt) || (state == SECOND);

    always_comb begin
        case (state)
            IDLE:    bus.addr = aligned_addr;
            FIRST:   bus.addr = bus.gnt ? next_addr : word_addr;
            SECOND:  bus.addr = next_addr;
            default: bus.addr = word_addr;
        endcase
    end

    // Requests held until granted, busy memory ignores the repeats
    assign bus.rd_req = (go && ld)
                     || (state == FIRST && op_load && (!bus.gnt || op_cross))
                     || (state == SECOND && op_load && !bus.gnt);
    assign bus.wr_req = (go && !ld)
                     || (state == FIRST && !op_load && (!bus.gnt || op_cross))
                     || (state == SECOND && !op_load && !bus.gnt);

    assign bus.wr_data = use_second ? second_data.word : first_data.word;
    assign bus.wr_mask = use_second ? second_mask : first_mask;

    // Live inputs in idle, since the first write issues in the start cycle
    assign st_data   = (state == IDLE) ? store_data : op_store_data;
    assign st_offset = (state == IDLE) ? addr[1:0] : op_offset;
    assign st_size   = (state == IDLE) ? data_size : op_size;

    lsu_store_align u_store_align (
        .store_data  (st_data),
        .offset      (st_offset),
        .size        (st_size),
        .first_data  (first_data),
        .second_data (second_data),
        .first_mask  (first_mask),
        .second_mask (second_mask)
    );

    lsu_load_align u_load_align (
        .cur_word  (bus.rd_data),
        .prev_word (prev_word),
        .offset    (op_offset),
        .size      (op_size),
        .uns       (op_uns),
        .result    (load_result)
    );

endmodule

`default_nettype wire

// File: design/lsu_load_align.sv
// Load data extraction from one or two memory words, with sign or zero extension
// Purely combinational; prev_word only matters for boundary-crossing loads
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  lsu_pkg::mem_word_u      cur_word,
    input  lsu_pkg::mem_word_u      prev_word,
    input  logic [1:0]              offset,
    input  lsu_pkg::access_size_t   size,
    input  logic                    uns,
    output logic [lsu_pkg::DATA_W-1:0] result
);
    import lsu_pkg::*;

    logic [7:0]        byte_val;
    logic [15:0]       half_val;
    logic [DATA_W-1:0] word_val;

    // ==================================================================
    // Lane selection

    // Bytes never cross, lane is the offset itself
    assign byte_val = cur_word.bytes[offset];

    always_comb begin
        case (offset)
            2'd0: half_val = {cur_word.bytes[1], cur_word.bytes[0]};
            2'd1: half_val = {cur_word.bytes[2], cur_word.bytes[1]};
            2'd2: half_val = {cur_word.bytes[3], cur_word.bytes[2]};
            // Crossing half, low byte sits in the top lane of the earlier word
            default: half_val = {cur_word.bytes[0], prev_word.bytes[3]};
        endcase
    end

    always_comb begin
        case (offset)
            2'd0: word_val = cur_word.word;
            // Upper lanes of prev hold the low-order bytes
            2'd1: word_val = {cur_word.bytes[0], prev_word.bytes[3:1]};
            2'd2: word_val = {cur_word.bytes[1:0], prev_word.bytes[3:2]};
            default: word_val = {cur_word.bytes[2:0], prev_word.bytes[3]};
        endcase
    end

    // ==================================================================
    // Extension to register width

    always_comb begin
        case (size)
            BYTE: begin
                if (uns) result = {{(DATA_W-8){1'b0}}, byte_val};
                else result = {{(DATA_W-8){byte_val[7]}}, byte_val};
            end
            HALF: begin
                if (uns) result = {{(DATA_W-16){1'b0}}, half_val};
                else result = {{(DATA_W-16){half_val[15]}}, half_val};
            end
            // Words need no extension
            default: result = word_val;
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
// Shared types and constants for the load/store unit and its data memory
// Imported by the LSU, the byte aligners, the bus interface and the SRAM model
`default_nettype none

package lsu_pkg;

    // Memory word geometry
    localparam int DATA_W    = 32;
    localparam int NUM_LANES = DATA_W / 8;

    // Access size, low bits of the load/store funct3 field
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } access_size_t;

    // One memory word, seen whole or lane by lane
    typedef union packed {
        logic [DATA_W-1:0]            word;
        logic [NUM_LANES-1:0][7:0]    bytes;
    } mem_word_u;

endpackage

`default_nettype wire

// File: design/lsu_store_align.sv
// Store data steering into byte lanes, with lane masks for one or two word writes
// Purely combinational; the second word is only written for crossing stores
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
    input  logic [lsu_pkg::DATA_W-1:0] store_data,
    input  logic [1:0]                 offset,
    input  lsu_pkg::access_size_t      size,
    output lsu_pkg::mem_word_u         first_data,
    output lsu_pkg::mem_word_u         second_data,
    output logic [lsu_pkg::NUM_LANES-1:0] first_mask,
    output logic [lsu_pkg::NUM_LANES-1:0] second_mask
);
    import lsu_pkg::*;

    logic [NUM_LANES-1:0]   span;
    logic [2*DATA_W-1:0]    data_pair;
    logic [2*NUM_LANES-1:0] mask_pair;

    // Lanes touched when the access starts at lane 0
    always_comb begin
        case (size)
            BYTE:    span = 4'b0001;
            HALF:    span = 4'b0011;
            WORD:    span = 4'b1111;
            default: span = 4'b0000;
        endcase
    end

    // ==================================================================
    // Lane steering over a two-word window

    // Shift by whole lanes, bytes past lane 3 land in the next word
    assign data_pair = {{DATA_W{1'b0}}, store_data} << (8 * offset);
    assign mask_pair = {{NUM_LANES{1'b0}}, span} << offset;

    // Low half goes to the addressed word
    assign first_data  = data_pair[DATA_W-1:0];
    assign first_mask  = mask_pair[NUM_LANES-1:0];

    // Spill into the following word, empty mask when aligned
    assign second_data = data_pair[2*DATA_W-1:DATA_W];
    assign second_mask = mask_pair[2*NUM_LANES-1:NUM_LANES];

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// LSU plus data memory, joined by the word bus
// Plain writeback-stage ports outside, memory geometry set here
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic                       clk,
    input  logic                       rstz,
    input  logic                       start,
    input  logic                       ld,
    input  logic                       st,
    input  logic [lsu_pkg::DATA_W-1:0] addr,
    input  logic [lsu_pkg::DATA_W-1:0] store_data,
    input  lsu_pkg::access_size_t      data_size,
    input  logic                       data_uns,
    input  logic [4:0]                 rd,
    output logic                       done,
    output logic                       load_en,
    output logic [lsu_pkg::DATA_W-1:0] load_data,
    output logic [4:0]                 load_rd
);

    data_bus_if bus ();

    // Sequencer on the writeback side
    lsu u_lsu (
        .clk        (clk),
        .rstz       (rstz),
        .start      (start),
        .ld         (ld),
        .st         (st),
        .addr       (addr),
        .store_data (store_data),
        .data_size  (data_size),
        .data_uns   (data_uns),
        .rd         (rd),
        .done       (done),
        .load_en    (load_en),
        .load_data  (load_data),
        .load_rd    (load_rd),
        .bus        (bus.lsu)
    );

    data_sram #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_sram (
        .clk  (clk),
        .rstz (rstz),
        .bus  (bus.mem)
    );

endmodule

`default_nettype wire

// File: list.f
design/lsu_pkg.sv
design/data_bus_if.sv
design/lsu_load_align.sv
design/lsu_store_align.sv
design/lsu.sv
design/data_sram.sv
design/lsu_top.sv
bench/lsu_tb.sv
